// File: kbd_seg_io.f
+incdir+rtl
rtl/kbd_seg_pkg.sv
rtl/kbd_fifo_if.sv
rtl/ps2_kbd.sv
rtl/hex_entry.sv
rtl/seg_serial.sv
rtl/kbd_seg_top.sv
verif/tb_kbd_seg_top.sv

// File: rtl/hex_entry.sv
// hex entry block that pops scan codes and shifts hex key digits into the display word
`timescale 1ns/1ps
`include "kbd_seg_consts.svh"

module hex_entry (
    input  logic                    clk200m,
    input  logic                    rst_n,
    kbd_fifo_if.sink                fifo,
    output kbd_seg_pkg::hex_word_t  disp_word,
    output kbd_seg_pkg::scan_code_t last_code
);

    logic       pop;
    logic       brk_pend;
    logic [4:0] hex_val;

    // bit 4 marks a hex key
    // bits 3:0 hold the digit value
    function automatic logic [4:0] decode_hex(input kbd_seg_pkg::scan_code_t code);
        logic [4:0] val;
        case (code)
            8'h45:   val = {1'b1, 4'h0};
            8'h16:   val = {1'b1, 4'h1};
            8'h1E:   val = {1'b1, 4'h2};
            8'h26:   val = {1'b1, 4'h3};
            8'h25:   val = {1'b1, 4'h4};
            8'h2E:   val = {1'b1, 4'h5};
            8'h36:   val = {1'b1, 4'h6};
            8'h3D:   val = {1'b1, 4'h7};
            8'h3E:   val = {1'b1, 4'h8};
            8'h46:   val = {1'b1, 4'h9};
            8'h1C:   val = {1'b1, 4'hA};
            8'h32:   val = {1'b1, 4'hB};
            8'h21:   val = {1'b1, 4'hC};
            8'h23:   val = {1'b1, 4'hD};
            8'h24:   val = {1'b1, 4'hE};
            8'h2B:   val = {1'b1, 4'hF};
            default: val = 5'h00;
        endcase
        return val;
    endfunction

    // one pop per cycle while anything is queued
    assign pop     = fifo.ready;
    assign fifo.rd = pop;
    assign hex_val = decode_hex(fifo.code);

    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            brk_pend  <= 1'b0;
            disp_word <= '0;
            last_code <= '0;
        end else if (pop) begin
            if (fifo.code == `KEY_BREAK) begin
                brk_pend <= 1'b1;
            end else if (brk_pend) begin
                // released key is swallowed
                brk_pend <= 1'b0;
            end else begin
                last_code <= fifo.code;
                if (fifo.code == `KEY_ESC) begin
                    disp_word <= '0;
                end else if (hex_val[4]) begin
                    // new digit enters from the right
                    disp_word <= {disp_word[27:0], hex_val[3:0]};
                end
            end
        end
    end

endmodule

// File: rtl/kbd_fifo_if.sv
// scan code queue link between the PS/2 receiver and the hex entry block
`timescale 1ns/1ps

interface kbd_fifo_if;

    kbd_seg_pkg::scan_code_t  code;
    logic                     ready;
    logic                     rd;
    kbd_seg_pkg::fifo_level_t level;

    // code is valid while ready is high
    // rd pops one entry
    modport source (
        output code,
        output ready,
        output level,
        input  rd
    );

    modport sink (
        input  code,
        input  ready,
        input  level,
        output rd
    );

endinterface

// File: rtl/kbd_seg_consts.svh
// keyboard and display constants for FIFO depth, PS/2 filter, segment divider and key codes
`ifndef KBD_SEG_CONSTS_SVH
`define KBD_SEG_CONSTS_SVH

// scan codes held between receiver and decoder
`define KBD_FIFO_DEPTH 8

// equal samples needed before the PS/2 clock level is taken
`define PS2_FILTER_LEN 4

// seg_clk = clk200m / 2**SEG_DIV_BITS
`define SEG_DIV_BITS 3

// set 2 break prefix
`define KEY_BREAK 8'hF0

// escape clears the display word
`define KEY_ESC 8'h76

`endif

// File: rtl/kbd_seg_pkg.sv
// keyboard and display types shared by receiver, decoder and segment driver
`include "kbd_seg_consts.svh"

package kbd_seg_pkg;

    // one PS/2 set 2 scan code
    typedef logic [7:0] scan_code_t;

    // eight hex digits
    // digit 0 sits in bits 3:0 and shows right-most
    typedef logic [31:0] hex_word_t;

    // eight segment bytes, digit 7 in the top byte
    // byte layout dp,g,f,e,d,c,b,a
    // a lit segment is 0
    typedef logic [63:0] seg_frame_t;

    // fill count of the scan code FIFO from 0 to full
    typedef logic [$clog2(`KBD_FIFO_DEPTH+1)-1:0] fifo_level_t;

endpackage

// File: rtl/kbd_seg_top.sv
// keyboard and display top level wiring the PS/2 receiver, hex entry and segment driver
`timescale 1ns/1ps

module kbd_seg_top (
    input  logic       clk200m,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] leds,
    output logic       seg_clk,
    output logic       seg_clrn,
    output logic       seg_dout,
    output logic       seg_en
);

    kbd_seg_pkg::hex_word_t  disp_word;
    kbd_seg_pkg::scan_code_t last_code;

    kbd_fifo_if u_fifo_if ();

    ps2_kbd u_ps2_kbd (
        .clk200m  (clk200m),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .fifo     (u_fifo_if.source)
    );

    hex_entry u_hex_entry (
        .clk200m   (clk200m),
        .rst_n     (rst_n),
        .fifo      (u_fifo_if.sink),
        .disp_word (disp_word),
        .last_code (last_code)
    );

    seg_serial u_seg_serial (
        .clk200m   (clk200m),
        .rst_n     (rst_n),
        .disp_word (disp_word),
        .seg_clk   (seg_clk),
        .seg_clrn  (seg_clrn),
        .seg_dout  (seg_dout),
        .seg_en    (seg_en)
    );

    // last accepted make code
    assign leds = last_code;

endmodule

// File: rtl/ps2_kbd.sv
// PS/2 keyboard receiver with line sync, clock filter, frame check and scan code FIFO
`timescale 1ns/1ps
`include "kbd_seg_consts.svh"

module ps2_kbd (
    input  logic       clk200m,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    kbd_fifo_if.source fifo
);

    localparam int PTR_W = $clog2(`KBD_FIFO_DEPTH);
    localparam int FLT_W = $clog2(`PS2_FILTER_LEN);

    logic [1:0]               clk_sync;
    logic [1:0]               data_sync;
    logic [FLT_W-1:0]         flt_cnt;
    logic                     clk_filt;
    logic                     clk_filt_q;
    logic                     fall;
    logic [9:0]               shift;
    logic [3:0]               bit_cnt;
    logic                     frame_ok;
    logic                     wr_req;
    kbd_seg_pkg::scan_code_t  wr_code;
    kbd_seg_pkg::scan_code_t  mem [`KBD_FIFO_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    kbd_seg_pkg::fifo_level_t count;
    logic                     do_wr;
    logic                     do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`KBD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // both lines idle high
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync   <= 2'b11;
            data_sync  <= 2'b11;
            flt_cnt    <= '0;
            clk_filt   <= 1'b1;
            clk_filt_q <= 1'b1;
        end else begin
            clk_sync   <= {clk_sync[0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            clk_filt_q <= clk_filt;
            // new level only after a run of equal samples
            if (clk_sync[1] == clk_filt) begin
                flt_cnt <= '0;
            end else if (flt_cnt == FLT_W'(`PS2_FILTER_LEN - 1)) begin
                flt_cnt  <= '0;
                clk_filt <= clk_sync[1];
            end else begin
                flt_cnt <= flt_cnt + 1'b1;
            end
        end
    end

    assign fall = clk_filt_q & ~clk_filt;

    // shift holds start, d0..d7, parity with start in bit 0
    // stop bit is the live sample on the eleventh edge
    assign frame_ok = ~shift[0] & (^shift[9:1]) & data_sync[1];

    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            wr_req  <= 1'b0;
        end else begin
            wr_req <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;
                    wr_req  <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk200m) begin
        if (fall) begin
            if (bit_cnt == 4'd10) begin
                wr_code <= shift[8:1];
            end else begin
                shift <= {data_sync[1], shift[9:1]};
            end
        end
    end

    // full FIFO drops the new code
    assign do_wr = wr_req && (count != `KBD_FIFO_DEPTH);
    assign do_rd = fifo.rd && fifo.ready;

    always_ff @(posedge clk200m) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_code;
        end
    end

    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign fifo.code  = mem[rd_ptr];
    assign fifo.ready = (count != '0);
    assign fifo.level = count;

endmodule

// File: rtl/seg_serial.sv
// serial segment driver that encodes the display word and shifts 64-bit frames out
`timescale 1ns/1ps
`include "kbd_seg_consts.svh"

module seg_serial (
    input  logic                   clk200m,
    input  logic                   rst_n,
    input  kbd_seg_pkg::hex_word_t disp_word,
    output logic                   seg_clk,
    output logic                   seg_clrn,
    output logic                   seg_dout,
    output logic                   seg_en
);

    localparam int FRAME_BITS   = 64;
    localparam int IDLE_PERIODS = 4;
    localparam int LAST_PER     = FRAME_BITS + IDLE_PERIODS - 1;

    logic [`SEG_DIV_BITS-1:0] div;
    logic                     tick;
    logic [6:0]               per_cnt;
    kbd_seg_pkg::seg_frame_t  shreg;
    kbd_seg_pkg::seg_frame_t  frame_next;

    // active low dp,g,f,e,d,c,b,a with dp dark
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nib);
        logic [7:0] seg;
        case (nib)
            4'h0:    seg = 8'hC0;
            4'h1:    seg = 8'hF9;
            4'h2:    seg = 8'hA4;
            4'h3:    seg = 8'hB0;
            4'h4:    seg = 8'h99;
            4'h5:    seg = 8'h92;
            4'h6:    seg = 8'h82;
            4'h7:    seg = 8'hF8;
            4'h8:    seg = 8'h80;
            4'h9:    seg = 8'h90;
            4'hA:    seg = 8'h88;
            4'hB:    seg = 8'h83;
            4'hC:    seg = 8'hC6;
            4'hD:    seg = 8'hA1;
            4'hE:    seg = 8'h86;
            default: seg = 8'h8E;
        endcase
        return seg;
    endfunction

    // digit i lands in byte i so digit 7 leaves first
    function automatic kbd_seg_pkg::seg_frame_t encode_word(input kbd_seg_pkg::hex_word_t w);
        kbd_seg_pkg::seg_frame_t f;
        for (int i = 0; i < 8; i++) begin
            f[i*8 +: 8] = hex_to_seg(w[i*4 +: 4]);
        end
        return f;
    endfunction

    assign frame_next = encode_word(disp_word);

    // tick marks the cycle before seg_clk falls
    assign tick     = &div;
    assign seg_clk  = div[`SEG_DIV_BITS-1];
    assign seg_dout = shreg[FRAME_BITS-1];

    // reset starts in the idle gap with the display held clear
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            div      <= '0;
            per_cnt  <= 7'(FRAME_BITS);
            seg_en   <= 1'b0;
            seg_clrn <= 1'b0;
            shreg    <= '1;
        end else begin
            div <= div + 1'b1;
            if (tick) begin
                if (per_cnt == 7'(LAST_PER)) begin
                    per_cnt  <= '0;
                    seg_en   <= 1'b1;
                    seg_clrn <= 1'b1;
                    shreg    <= frame_next;
                end else begin
                    per_cnt <= per_cnt + 1'b1;
                    // ones fill in behind so the line idles high
                    shreg   <= {shreg[FRAME_BITS-2:0], 1'b1};
                    if (per_cnt == 7'(FRAME_BITS - 1)) begin
                        seg_en <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: verif/kbd_seg_trace.txt
# K <scan code hex> <1 = corrupt parity> sends one PS/2 frame
# C <expected segment frame hex, digit 7 first> <expected leds hex> checks the display
C C0C0C0C0C0C0C0C0 00
K 16 0
K 1E 0
K 26 0
C C0C0C0C0C0F9A4B0 26
K 1C 0
K F0 0
K 1C 0
K 32 0
K F0 0
K 32 0
C C0C0C0F9A4B08883 32
K 15 0
C C0C0C0F9A4B08883 15
K 76 0
C C0C0C0C0C0C0C0C0 76
K 2E 1
C C0C0C0C0C0C0C0C0 76
K 24 0
C C0C0C0C0C0C0C086 24
K 16 0
K 1E 0
K 26 0
K 25 0
K 2E 0
K 36 0
K 3D 0
K 3E 0
K 46 0
C A4B0999282F88090 46

// File: verif/tb_kbd_seg_top.sv
// keyboard and display testbench that sends PS/2 frames from a trace and checks segment frames
`timescale 1ns/1ps

module tb_kbd_seg_top;

    localparam int HALF_PER  = 40;
    localparam int FRAME_CYC = 68 * 8;
    localparam int KEY_CYC   = 11 * 80 + 164;

    logic        clk200m;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic [7:0]  leds;
    logic        seg_clk;
    logic        seg_clrn;
    logic        seg_dout;
    logic        seg_en;

    byte         tr_kind[$];
    logic [63:0] tr_val[$];
    logic [7:0]  tr_aux[$];

    int          errors = 0;
    int          checks = 0;
    int          watch_cycles = 0;
    int          frame_cnt = 0;
    int          col_bits = 0;
    logic [63:0] col_shift = '0;
    logic [63:0] last_frame = '0;
    logic [31:0] lfsr = 32'h4fe5_52ab;
    int          fd;

    kbd_seg_top i_dut (
        .clk200m  (clk200m),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .leds     (leds),
        .seg_clk  (seg_clk),
        .seg_clrn (seg_clrn),
        .seg_dout (seg_dout),
        .seg_en   (seg_en)
    );

    initial begin
        clk200m = 1'b0;
        forever #4 clk200m = ~clk200m;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // start, 8 data bits lsb first, odd parity, stop
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        int          gap;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk200m);
            ps2_data <= bits[i];
            repeat (HALF_PER / 2) @(posedge clk200m);
            ps2_clk <= 1'b0;
            repeat (HALF_PER) @(posedge clk200m);
            ps2_clk <= 1'b1;
            repeat (HALF_PER / 2 - 1) @(posedge clk200m);
        end
        random_bits(6, gap);
        repeat (100 + gap) @(posedge clk200m);
    endtask

    // first frame may have been loaded before the last key landed
    task automatic check_display(input logic [63:0] exp_frame, input logic [7:0] exp_leds);
        int start;
        start = frame_cnt;
        wait (frame_cnt >= start + 2);
        check_value("segment frame", last_frame, exp_frame);
        check_value("leds", leds, exp_leds);
        check_value("seg_clrn", seg_clrn, 1'b1);
    endtask

    task automatic load_trace(input int f);
        string       line;
        byte         kind;
        logic [63:0] a;
        logic [63:0] b;
        int          n;
        while (!$feof(f)) begin
            line = "";
            void'($fgets(line, f));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h", kind, a, b);
            if (n == 3 && (kind == "K" || kind == "C")) begin
                tr_kind.push_back(kind);
                tr_val.push_back(a);
                tr_aux.push_back(b[7:0]);
            end else begin
                errors++;
                $display("trace line could not be read: %s", line);
            end
        end
        $fclose(f);
    endtask

    // collector with the msb of the frame arriving first
    // falling seg_en closes the frame
    always @(posedge seg_clk or negedge seg_en) begin
        if (!seg_en) begin
            if (col_bits == 64) begin
                last_frame = col_shift;
                frame_cnt  = frame_cnt + 1;
            end else if (col_bits != 0) begin
                errors++;
                $display("segment frame ended after %0d bits instead of 64", col_bits);
            end
            col_bits = 0;
        end else if (rst_n) begin
            col_shift = {col_shift[62:0], seg_dout};
            col_bits  = col_bits + 1;
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk200m);
        $display("timeout: run did not finish within %0d cycles", watch_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        fd = $fopen("verif/kbd_seg_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file verif/kbd_seg_trace.txt could not be opened");
            $display(">>> FAIL");
            $finish;
        end else begin
            load_trace(fd);
            watch_cycles = 16 + tr_kind.size() * KEY_CYC;
            foreach (tr_kind[i]) begin
                if (tr_kind[i] == "C") begin
                    watch_cycles += 3 * FRAME_CYC;
                end
            end
            repeat (2) @(posedge clk200m);
            rst_n <= 1'b1;
            @(posedge clk200m);
            // idle gap right after reset
            check_value("seg_en after reset", seg_en, 1'b0);
            check_value("seg_clk after reset", seg_clk, 1'b0);
            check_value("seg_clrn after reset", seg_clrn, 1'b0);
            check_value("seg_dout after reset", seg_dout, 1'b1);
            check_value("leds after reset", leds, 8'h00);
            for (int i = 0; i < tr_kind.size(); i++) begin
                if (tr_kind[i] == "K") begin
                    send_ps2_frame(tr_val[i][7:0], tr_aux[i][0]);
                end else begin
                    check_display(tr_val[i], tr_aux[i]);
                end
            end
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule
